/* src/rv_pkg.sv */
`default_nettype none

package rv_pkg;

  localparam int XLEN = 32;

  typedef logic [XLEN-1:0] reg_t;
  typedef logic [4:0]      reg_addr_t;
  typedef logic [7:0]      bus_addr_t;

  // ABI indices that get their own storage
  localparam reg_addr_t REG_ZERO = 5'd0;
  localparam reg_addr_t REG_RA   = 5'd1;
  localparam reg_addr_t REG_SP   = 5'd2;

  localparam reg_t RA_GUARD = {XLEN{1'b1}};
  localparam reg_t SP_RESET = 32'h0000_1000;

  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLL     = 3'b001;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_SLTU    = 3'b011;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_SR      = 3'b101;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;

  // Selects SUB and SRA/SRAI
  localparam logic [6:0] F7_ALT = 7'b0100000;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_SLT,
    ALU_SLTU
  } alu_op_t;

  // Same instruction word seen as R-type or I-type
  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      reg_addr_t  rs2;
      reg_addr_t  rs1;
      logic [2:0] funct3;
      reg_addr_t  rd;
      logic [6:0] opcode;
    } r;
    struct packed {
      logic [11:0] imm12;
      reg_addr_t   rs1;
      logic [2:0]  funct3;
      reg_addr_t   rd;
      logic [6:0]  opcode;
    } i;
  } instr_u;

  // Byte addresses on the bus
  localparam bus_addr_t ADDR_INSTR    = 8'h00;
  localparam bus_addr_t ADDR_RA_GUARD = 8'h04;
  localparam bus_addr_t ADDR_REG_BASE = 8'h80;

endpackage

`default_nettype wire

/* src/reg_bank.sv */
`timescale 1ns/10ps
`default_nettype none

module reg_bank #(
  parameter int unsigned NUM_REGS = 32,
  localparam int unsigned AW = (NUM_REGS > 1) ? $clog2(NUM_REGS) : 1
) (
  input  wire               clk_i,
  input  wire               rst_i,
  input  wire rv_pkg::reg_t rst_value_i,
  input  wire [AW-1:0]      raddr_a_i,
  input  wire [AW-1:0]      raddr_b_i,
  input  wire [AW-1:0]      waddr_i,
  output rv_pkg::reg_t      rdata_a_o,
  output rv_pkg::reg_t      rdata_b_o,
  input  wire rv_pkg::reg_t wdata_i,
  input  wire               we_i
);

  rv_pkg::reg_t mem [NUM_REGS];

  // Combinational read ports
  assign rdata_a_o = mem[raddr_a_i];
  assign rdata_b_o = mem[raddr_b_i];

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int k = 0; k < NUM_REGS; k++) begin
        mem[k] <= rst_value_i;
      end
    end else if (we_i) begin
      mem[waddr_i] <= wdata_i;
    end
  end

  // Caller must keep the local index inside the bank
  a_waddr_in_range : assert property (
    @(posedge clk_i) disable iff (rst_i)
    we_i |-> (waddr_i < NUM_REGS)
  ) else $error("reg_bank write index %0d out of range", waddr_i);

endmodule

`default_nettype wire

/* src/register_file.sv */
`timescale 1ns/10ps
`default_nettype none

module register_file (
  input  wire                    clk_i,
  input  wire                    rst_i,
  input  wire rv_pkg::reg_addr_t raddr_a_i,
  input  wire rv_pkg::reg_addr_t raddr_b_i,
  input  wire rv_pkg::reg_addr_t waddr_i,
  output rv_pkg::reg_t           rdata_a_o,
  output rv_pkg::reg_t           rdata_b_o,
  input  wire rv_pkg::reg_t      wdata_i,
  input  wire                    we_i,
  input  wire                    ra_set_i
);

  rv_pkg::reg_addr_t gp_raddr_a;
  rv_pkg::reg_addr_t gp_raddr_b;
  rv_pkg::reg_addr_t gp_waddr;
  rv_pkg::reg_t      gp_rdata_a;
  rv_pkg::reg_t      gp_rdata_b;
  logic              gp_we;

  rv_pkg::reg_t      ra_rdata_a;
  rv_pkg::reg_t      ra_rdata_b;
  rv_pkg::reg_t      ra_wdata;
  logic              ra_we;

  rv_pkg::reg_t      sp_rdata_a;
  rv_pkg::reg_t      sp_rdata_b;
  logic              sp_we;

  // x3..x31 live at local index 0..28
  assign gp_raddr_a = raddr_a_i - 5'd3;
  assign gp_raddr_b = raddr_b_i - 5'd3;
  assign gp_waddr   = waddr_i - 5'd3;

  assign gp_we = we_i && (waddr_i > rv_pkg::REG_SP);
  assign sp_we = we_i && (waddr_i == rv_pkg::REG_SP);

  // Guard load wins over the data path
  assign ra_we    = (we_i && (waddr_i == rv_pkg::REG_RA)) || ra_set_i;
  assign ra_wdata = ra_set_i ? rv_pkg::RA_GUARD : wdata_i;

  reg_bank #(.NUM_REGS(29)) gp_bank (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .rst_value_i ('0),
    .raddr_a_i   (gp_raddr_a),
    .raddr_b_i   (gp_raddr_b),
    .waddr_i     (gp_waddr),
    .rdata_a_o   (gp_rdata_a),
    .rdata_b_o   (gp_rdata_b),
    .wdata_i     (wdata_i),
    .we_i        (gp_we)
  );

  reg_bank #(.NUM_REGS(1)) ra_bank (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .rst_value_i ('0),
    .raddr_a_i   (1'b0),
    .raddr_b_i   (1'b0),
    .waddr_i     (1'b0),
    .rdata_a_o   (ra_rdata_a),
    .rdata_b_o   (ra_rdata_b),
    .wdata_i     (ra_wdata),
    .we_i        (ra_we)
  );

  reg_bank #(.NUM_REGS(1)) sp_bank (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .rst_value_i (rv_pkg::SP_RESET),
    .raddr_a_i   (1'b0),
    .raddr_b_i   (1'b0),
    .waddr_i     (1'b0),
    .rdata_a_o   (sp_rdata_a),
    .rdata_b_o   (sp_rdata_b),
    .wdata_i     (wdata_i),
    .we_i        (sp_we)
  );

  function automatic rv_pkg::reg_t steer(
    input rv_pkg::reg_addr_t idx,
    input rv_pkg::reg_t      ra_val,
    input rv_pkg::reg_t      sp_val,
    input rv_pkg::reg_t      gp_val
  );
    rv_pkg::reg_t val;
    case (idx)
      rv_pkg::REG_ZERO: val = '0;
      rv_pkg::REG_RA:   val = ra_val;
      rv_pkg::REG_SP:   val = sp_val;
      default:          val = gp_val;
    endcase
    return val;
  endfunction

  assign rdata_a_o = steer(raddr_a_i, ra_rdata_a, sp_rdata_a, gp_rdata_a);
  assign rdata_b_o = steer(raddr_b_i, ra_rdata_b, sp_rdata_b, gp_rdata_b);

  // Slave issues guard loads and instruction writes in separate bus cycles
  a_no_set_and_write : assert property (
    @(posedge clk_i) disable iff (rst_i)
    !(ra_set_i && we_i)
  ) else $error("ra guard load collides with an instruction write");

endmodule

`default_nettype wire

/* src/instr_decoder.sv */
`timescale 1ns/10ps
`default_nettype none

module instr_decoder (
  input  wire rv_pkg::reg_t instr_i,
  output rv_pkg::reg_addr_t rs1_o,
  output rv_pkg::reg_addr_t rs2_o,
  output rv_pkg::reg_addr_t rd_o,
  output rv_pkg::alu_op_t   alu_op_o,
  output logic              use_imm_o,
  output rv_pkg::reg_t      imm_o,
  output logic              legal_o
);

  rv_pkg::instr_u instr;
  logic [6:0]     imm_hi;

  assign instr  = instr_i;
  assign imm_hi = instr.i.imm12[11:5];

  // Shared by both groups; alt only matters for ADD/SUB and SRL/SRA
  function automatic rv_pkg::alu_op_t f3_to_op(input logic [2:0] f3, input logic alt);
    rv_pkg::alu_op_t op;
    case (f3)
      rv_pkg::F3_ADD_SUB: op = alt ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
      rv_pkg::F3_SLL:     op = rv_pkg::ALU_SLL;
      rv_pkg::F3_SLT:     op = rv_pkg::ALU_SLT;
      rv_pkg::F3_SLTU:    op = rv_pkg::ALU_SLTU;
      rv_pkg::F3_XOR:     op = rv_pkg::ALU_XOR;
      rv_pkg::F3_SR:      op = alt ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
      rv_pkg::F3_OR:      op = rv_pkg::ALU_OR;
      default:            op = rv_pkg::ALU_AND;
    endcase
    return op;
  endfunction

  assign rs1_o = instr.r.rs1;
  assign rs2_o = instr.r.rs2;
  assign rd_o  = instr.r.rd;
  assign imm_o = {{(rv_pkg::XLEN-12){instr.i.imm12[11]}}, instr.i.imm12};

  always_comb begin
    alu_op_o  = rv_pkg::ALU_ADD;
    use_imm_o = 1'b0;
    legal_o   = 1'b0;
    case (instr.r.opcode)
      rv_pkg::OPC_OP: begin
        alu_op_o = f3_to_op(instr.r.funct3, instr.r.funct7 == rv_pkg::F7_ALT);
        if (instr.r.funct7 == 7'd0) begin
          legal_o = 1'b1;
        end else if (instr.r.funct7 == rv_pkg::F7_ALT) begin
          legal_o = (instr.r.funct3 == rv_pkg::F3_ADD_SUB) ||
                    (instr.r.funct3 == rv_pkg::F3_SR);
        end
      end
      rv_pkg::OPC_OP_IMM: begin
        use_imm_o = 1'b1;
        // ADDI never turns into a subtract
        alu_op_o  = f3_to_op(instr.i.funct3,
                             (instr.i.funct3 == rv_pkg::F3_SR) && (imm_hi == rv_pkg::F7_ALT));
        case (instr.i.funct3)
          rv_pkg::F3_SLL: legal_o = (imm_hi == 7'd0);
          rv_pkg::F3_SR:  legal_o = (imm_hi == 7'd0) || (imm_hi == rv_pkg::F7_ALT);
          default:        legal_o = 1'b1;
        endcase
      end
      default: begin
        legal_o = 1'b0;
      end
    endcase
  end

endmodule

`default_nettype wire

/* src/alu.sv */
`timescale 1ns/10ps
`default_nettype none

module alu (
  input  wire rv_pkg::alu_op_t op_i,
  input  wire rv_pkg::reg_t    a_i,
  input  wire rv_pkg::reg_t    b_i,
  output rv_pkg::reg_t         result_o
);

  logic [4:0] shamt;
  logic       lt_signed;
  logic       lt_unsigned;

  // Only the low five bits of b count as shift amount
  assign shamt       = b_i[4:0];
  assign lt_signed   = $signed(a_i) < $signed(b_i);
  assign lt_unsigned = a_i < b_i;

  always_comb begin
    case (op_i)
      rv_pkg::ALU_ADD:  result_o = a_i + b_i;
      rv_pkg::ALU_SUB:  result_o = a_i - b_i;
      rv_pkg::ALU_AND:  result_o = a_i & b_i;
      rv_pkg::ALU_OR:   result_o = a_i | b_i;
      rv_pkg::ALU_XOR:  result_o = a_i ^ b_i;
      rv_pkg::ALU_SLL:  result_o = a_i << shamt;
      rv_pkg::ALU_SRL:  result_o = a_i >> shamt;
      rv_pkg::ALU_SRA:  result_o = rv_pkg::reg_t'($signed(a_i) >>> shamt);
      rv_pkg::ALU_SLT:  result_o = {{(rv_pkg::XLEN-1){1'b0}}, lt_signed};
      rv_pkg::ALU_SLTU: result_o = {{(rv_pkg::XLEN-1){1'b0}}, lt_unsigned};
      default:          result_o = '0;
    endcase
  end

endmodule

`default_nettype wire

/* src/wb_exec_slave.sv */
`timescale 1ns/10ps
`default_nettype none

module wb_exec_slave (
  input  wire                    clk_i,
  input  wire                    rst_i,
  input  wire                    wb_cyc_i,
  input  wire                    wb_stb_i,
  input  wire                    wb_we_i,
  input  wire rv_pkg::bus_addr_t wb_adr_i,
  input  wire rv_pkg::reg_t      wb_dat_i,
  output rv_pkg::reg_t           wb_dat_o,
  output logic                   wb_ack_o,
  output logic                   wb_err_o,
  input  wire                    legal_i,
  input  wire rv_pkg::reg_t      rdata_a_i,
  input  wire rv_pkg::reg_addr_t rs1_i,
  output rv_pkg::reg_addr_t      raddr_a_o,
  output logic                   rf_we_o,
  output logic                   ra_set_o
);

  logic              req;
  logic              is_instr;
  logic              is_guard;
  logic              in_win;
  logic              resp_ok;
  logic              win_read;
  rv_pkg::bus_addr_t win_off;
  rv_pkg::reg_t      rd_data;

  // New request only while no response is being driven
  assign req = wb_cyc_i && wb_stb_i && !wb_ack_o && !wb_err_o;

  assign is_instr = (wb_adr_i == rv_pkg::ADDR_INSTR);
  assign is_guard = (wb_adr_i == rv_pkg::ADDR_RA_GUARD);
  assign win_off  = wb_adr_i - rv_pkg::ADDR_REG_BASE;
  assign in_win   = (wb_adr_i >= rv_pkg::ADDR_REG_BASE) && (win_off[1:0] == 2'b00);
  assign win_read = in_win && !wb_we_i;

  // Window is read-only; the instruction slot only takes legal words
  always_comb begin
    if (wb_we_i) begin
      resp_ok = (is_instr && legal_i) || is_guard;
    end else begin
      resp_ok = is_instr || is_guard || in_win;
    end
  end

  // Debug reads borrow port a of the register file
  assign raddr_a_o = win_read ? win_off[6:2] : rs1_i;
  assign rd_data   = win_read ? rdata_a_i : '0;

  // Write-back lands on the acknowledging edge
  assign rf_we_o  = req && wb_we_i && is_instr && legal_i;
  assign ra_set_o = req && wb_we_i && is_guard;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wb_ack_o <= 1'b0;
      wb_err_o <= 1'b0;
    end else begin
      wb_ack_o <= req && resp_ok;
      wb_err_o <= req && !resp_ok;
    end
  end

  // Captures pre-edge register state for the ack cycle
  always_ff @(posedge clk_i) begin
    if (req && !wb_we_i) begin
      wb_dat_o <= rd_data;
    end
  end

  a_ack_err_exclusive : assert property (
    @(posedge clk_i) disable iff (rst_i)
    !(wb_ack_o && wb_err_o)
  ) else $error("ack and err raised together");

  // Responses last exactly one cycle
  a_resp_single_cycle : assert property (
    @(posedge clk_i) disable iff (rst_i)
    (wb_ack_o || wb_err_o) |=> !(wb_ack_o || wb_err_o)
  ) else $error("bus response held longer than one cycle");

  // The instruction slot is only decoded for writes
  a_dat_unused : assert property (
    @(posedge clk_i) disable iff (rst_i)
    rf_we_o |-> !$isunknown(wb_dat_i)
  ) else $error("instruction word unknown during write-back");

endmodule

`default_nettype wire

/* src/exec_unit_top.sv */
`timescale 1ns/10ps
`default_nettype none

module exec_unit_top (
  input  wire                    clk_i,
  input  wire                    rst_i,
  input  wire                    wb_cyc_i,
  input  wire                    wb_stb_i,
  input  wire                    wb_we_i,
  input  wire rv_pkg::bus_addr_t wb_adr_i,
  input  wire rv_pkg::reg_t      wb_dat_i,
  output rv_pkg::reg_t           wb_dat_o,
  output logic                   wb_ack_o,
  output logic                   wb_err_o
);

  rv_pkg::reg_addr_t rs1;
  rv_pkg::reg_addr_t rs2;
  rv_pkg::reg_addr_t rd;
  rv_pkg::reg_addr_t raddr_a;
  rv_pkg::alu_op_t   alu_op;
  logic              use_imm;
  logic              legal;
  logic              rf_we;
  logic              ra_set;
  rv_pkg::reg_t      imm;
  rv_pkg::reg_t      rdata_a;
  rv_pkg::reg_t      rdata_b;
  rv_pkg::reg_t      alu_b;
  rv_pkg::reg_t      result;

  wb_exec_slave u_slave (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .wb_cyc_i  (wb_cyc_i),
    .wb_stb_i  (wb_stb_i),
    .wb_we_i   (wb_we_i),
    .wb_adr_i  (wb_adr_i),
    .wb_dat_i  (wb_dat_i),
    .wb_dat_o  (wb_dat_o),
    .wb_ack_o  (wb_ack_o),
    .wb_err_o  (wb_err_o),
    .legal_i   (legal),
    .rdata_a_i (rdata_a),
    .rs1_i     (rs1),
    .raddr_a_o (raddr_a),
    .rf_we_o   (rf_we),
    .ra_set_o  (ra_set)
  );

  instr_decoder u_decoder (
    .instr_i   (wb_dat_i),
    .rs1_o     (rs1),
    .rs2_o     (rs2),
    .rd_o      (rd),
    .alu_op_o  (alu_op),
    .use_imm_o (use_imm),
    .imm_o     (imm),
    .legal_o   (legal)
  );

  // Operand b is a register or the sign-extended immediate
  assign alu_b = use_imm ? imm : rdata_b;

  alu u_alu (
    .op_i     (alu_op),
    .a_i      (rdata_a),
    .b_i      (alu_b),
    .result_o (result)
  );

  register_file u_regfile (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .raddr_a_i (raddr_a),
    .raddr_b_i (rs2),
    .waddr_i   (rd),
    .rdata_a_o (rdata_a),
    .rdata_b_o (rdata_b),
    .wdata_i   (result),
    .we_i      (rf_we),
    .ra_set_i  (ra_set)
  );

endmodule

`default_nettype wire

/* dv/clk_gen.sv */
`timescale 1ns/10ps
`default_nettype none

module clk_gen #(
  parameter int HALF_PERIOD  = 50,
  parameter int RESET_CYCLES = 5
) (
  output logic clk_o,
  output logic rst_o
);

  initial begin
    clk_o = 1'b0;
    forever begin
      #(HALF_PERIOD);
      clk_o = ~clk_o;
    end
  end

  // Reset released just after the last reset edge
  initial begin
    rst_o = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk_o);
    #1;
    rst_o = 1'b0;
  end

endmodule

`default_nettype wire

/* dv/exec_unit_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module exec_unit_tb #(
  parameter int DRIVE_DELAY = 1
);

  logic              clk;
  logic              rst;
  logic              wb_cyc;
  logic              wb_stb;
  logic              wb_we;
  rv_pkg::bus_addr_t wb_adr;
  rv_pkg::reg_t      wb_dat;
  rv_pkg::reg_t      wb_rdata;
  logic              wb_ack;
  logic              wb_err;

  // Stimulus table with one entry per bus cycle
  bit                row_write[$];
  rv_pkg::bus_addr_t row_addr[$];
  rv_pkg::reg_t      row_data[$];
  rv_pkg::reg_t      row_exp[$];
  logic              row_err[$];
  string             row_name[$];

  integer            seed;
  int                cycle_count = 0;
  int                cycle_limit = 0;

  clk_gen u_clk_gen (
    .clk_o (clk),
    .rst_o (rst)
  );

  exec_unit_top dut_i (
    .clk_i    (clk),
    .rst_i    (rst),
    .wb_cyc_i (wb_cyc),
    .wb_stb_i (wb_stb),
    .wb_we_i  (wb_we),
    .wb_adr_i (wb_adr),
    .wb_dat_i (wb_dat),
    .wb_dat_o (wb_rdata),
    .wb_ack_o (wb_ack),
    .wb_err_o (wb_err)
  );

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Verification failed");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic check_word(input string name, input rv_pkg::reg_t exp, input rv_pkg::reg_t act);
    if (act !== exp) begin
      abort_run($sformatf("MISMATCH %s: expected 0x%08h, actual 0x%08h", name, exp, act));
    end
  endtask

  task automatic check_resp(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      abort_run($sformatf("MISMATCH %s: expected %0b, actual %0b", name, exp, act));
    end
  endtask

  function automatic rv_pkg::reg_t enc_r(input logic [6:0] f7, input rv_pkg::reg_addr_t rs2,
      input rv_pkg::reg_addr_t rs1, input logic [2:0] f3, input rv_pkg::reg_addr_t rd);
    return {f7, rs2, rs1, f3, rd, rv_pkg::OPC_OP};
  endfunction

  function automatic rv_pkg::reg_t enc_i(input logic [11:0] imm, input rv_pkg::reg_addr_t rs1,
      input logic [2:0] f3, input rv_pkg::reg_addr_t rd);
    return {imm, rs1, f3, rd, rv_pkg::OPC_OP_IMM};
  endfunction

  function automatic rv_pkg::reg_t sext12(input logic [11:0] imm);
    return {{20{imm[11]}}, imm};
  endfunction

  // Register n sits at base plus 4n
  function automatic rv_pkg::bus_addr_t win_addr(input rv_pkg::reg_addr_t n);
    return rv_pkg::ADDR_REG_BASE | {1'b0, n, 2'b00};
  endfunction

  function automatic void add_row(input bit is_write, input rv_pkg::bus_addr_t addr,
      input rv_pkg::reg_t data, input rv_pkg::reg_t exp, input logic exp_err, input string name);
    row_write.push_back(is_write);
    row_addr.push_back(addr);
    row_data.push_back(data);
    row_exp.push_back(exp);
    row_err.push_back(exp_err);
    row_name.push_back(name);
  endfunction

  function automatic void add_write(input rv_pkg::bus_addr_t addr, input rv_pkg::reg_t data,
      input logic exp_err, input string name);
    add_row(1'b1, addr, data, '0, exp_err, name);
  endfunction

  function automatic void add_read(input rv_pkg::bus_addr_t addr, input rv_pkg::reg_t exp,
      input logic exp_err, input string name);
    add_row(1'b0, addr, '0, exp, exp_err, name);
  endfunction

  function automatic void issue_legal(input rv_pkg::reg_t instr, input string name);
    add_write(rv_pkg::ADDR_INSTR, instr, 1'b0, name);
  endfunction

  function automatic void issue_illegal(input rv_pkg::reg_t instr, input string name);
    add_write(rv_pkg::ADDR_INSTR, instr, 1'b1, name);
  endfunction

  function automatic void expect_reg(input rv_pkg::reg_addr_t n, input rv_pkg::reg_t exp,
      input string name);
    add_read(win_addr(n), exp, 1'b0, name);
  endfunction

  // One Wishbone classic transaction that returns read data and both response flags
  task automatic bus_cycle(input bit we, input rv_pkg::bus_addr_t addr, input rv_pkg::reg_t data,
      output rv_pkg::reg_t rdata, output logic ack, output logic err);
    logic got_resp;
    @(posedge clk);
    #(DRIVE_DELAY);
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we  = we;
    wb_adr = addr;
    wb_dat = data;
    got_resp = 1'b0;
    while (!got_resp) begin
      @(posedge clk);
      #(DRIVE_DELAY);
      got_resp = wb_ack || wb_err;
    end
    rdata  = wb_rdata;
    ack    = wb_ack;
    err    = wb_err;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
      abort_run($sformatf("Timeout: run did not finish within %0d clock cycles", cycle_limit));
    end
  end

  initial begin
    rv_pkg::reg_t rdata;
    logic         got_ack;
    logic         got_err;
    rv_pkg::reg_t rnd;
    logic [11:0]  imm_a;
    logic [11:0]  imm_b;

    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
    wb_adr = '0;
    wb_dat = '0;
    seed   = 32'hf569;

    // Reset state and address map
    expect_reg(5'd0, 32'h0000_0000, "x0 after reset");
    expect_reg(5'd1, 32'h0000_0000, "ra after reset");
    expect_reg(5'd2, 32'h0000_1000, "sp after reset");
    expect_reg(5'd5, 32'h0000_0000, "x5 after reset");
    add_read(rv_pkg::ADDR_INSTR, 32'h0, 1'b0, "read instr slot");
    add_read(rv_pkg::ADDR_RA_GUARD, 32'h0, 1'b0, "read guard slot");
    add_read(8'h08, 32'h0, 1'b1, "read unmapped");
    add_read(8'h81, 32'h0, 1'b1, "read misaligned window");

    // Immediate group
    issue_legal(enc_i(12'd100, 5'd0, rv_pkg::F3_ADD_SUB, 5'd5), "addi x5, x0, 100");
    expect_reg(5'd5, 32'h0000_0064, "x5 addi");
    issue_legal(enc_i(12'hffb, 5'd0, rv_pkg::F3_ADD_SUB, 5'd6), "addi x6, x0, -5");
    expect_reg(5'd6, 32'hffff_fffb, "x6 addi negative");
    issue_legal(enc_i(12'h0f0, 5'd6, rv_pkg::F3_AND, 5'd7), "andi x7, x6, 0xf0");
    expect_reg(5'd7, 32'h0000_00f0, "x7 andi");
    issue_legal(enc_i(12'h700, 5'd5, rv_pkg::F3_OR, 5'd8), "ori x8, x5, 0x700");
    expect_reg(5'd8, 32'h0000_0764, "x8 ori");
    issue_legal(enc_i(12'hfff, 5'd6, rv_pkg::F3_XOR, 5'd9), "xori x9, x6, -1");
    expect_reg(5'd9, 32'h0000_0004, "x9 xori");
    issue_legal(enc_i(12'd0, 5'd6, rv_pkg::F3_SLT, 5'd10), "slti x10, x6, 0");
    expect_reg(5'd10, 32'h0000_0001, "x10 slti");
    issue_legal(enc_i(12'd5, 5'd6, rv_pkg::F3_SLTU, 5'd11), "sltiu x11, x6, 5");
    expect_reg(5'd11, 32'h0000_0000, "x11 sltiu");
    issue_legal(enc_i(12'd4, 5'd5, rv_pkg::F3_SLL, 5'd13), "slli x13, x5, 4");
    expect_reg(5'd13, 32'h0000_0640, "x13 slli");
    issue_legal(enc_i(12'd28, 5'd6, rv_pkg::F3_SR, 5'd14), "srli x14, x6, 28");
    expect_reg(5'd14, 32'h0000_000f, "x14 srli");
    issue_legal(enc_i({rv_pkg::F7_ALT, 5'd1}, 5'd6, rv_pkg::F3_SR, 5'd15), "srai x15, x6, 1");
    expect_reg(5'd15, 32'hffff_fffd, "x15 srai");

    // Random immediates with sign-extended results
    rnd   = $random(seed);
    imm_a = rnd[11:0];
    rnd   = $random(seed);
    imm_b = rnd[11:0];
    issue_legal(enc_i(imm_a, 5'd0, rv_pkg::F3_ADD_SUB, 5'd16), "addi x16, x0, random");
    expect_reg(5'd16, sext12(imm_a), "x16 random addi");
    issue_legal(enc_i(imm_b, 5'd5, rv_pkg::F3_XOR, 5'd17), "xori x17, x5, random");
    expect_reg(5'd17, 32'h0000_0064 ^ sext12(imm_b), "x17 random xori");

    // Register-register group
    issue_legal(enc_r(7'd0, 5'd6, 5'd5, rv_pkg::F3_ADD_SUB, 5'd18), "add x18, x5, x6");
    expect_reg(5'd18, 32'h0000_005f, "x18 add");
    issue_legal(enc_r(rv_pkg::F7_ALT, 5'd5, 5'd9, rv_pkg::F3_ADD_SUB, 5'd19), "sub x19, x9, x5");
    expect_reg(5'd19, 32'hffff_ffa0, "x19 sub underflow");
    issue_legal(enc_r(7'd0, 5'd8, 5'd6, rv_pkg::F3_AND, 5'd20), "and x20, x6, x8");
    expect_reg(5'd20, 32'h0000_0760, "x20 and");
    issue_legal(enc_r(7'd0, 5'd9, 5'd7, rv_pkg::F3_OR, 5'd21), "or x21, x7, x9");
    expect_reg(5'd21, 32'h0000_00f4, "x21 or");
    issue_legal(enc_r(7'd0, 5'd5, 5'd6, rv_pkg::F3_XOR, 5'd22), "xor x22, x6, x5");
    expect_reg(5'd22, 32'hffff_ff9f, "x22 xor");
    issue_legal(enc_r(7'd0, 5'd14, 5'd5, rv_pkg::F3_SLL, 5'd23), "sll x23, x5, x14");
    expect_reg(5'd23, 32'h0032_0000, "x23 sll");
    issue_legal(enc_r(7'd0, 5'd10, 5'd19, rv_pkg::F3_SR, 5'd24), "srl x24, x19, x10");
    expect_reg(5'd24, 32'h7fff_ffd0, "x24 srl negative");
    issue_legal(enc_r(rv_pkg::F7_ALT, 5'd10, 5'd19, rv_pkg::F3_SR, 5'd25), "sra x25, x19, x10");
    expect_reg(5'd25, 32'hffff_ffd0, "x25 sra negative");
    issue_legal(enc_r(7'd0, 5'd5, 5'd19, rv_pkg::F3_SLT, 5'd26), "slt x26, x19, x5");
    expect_reg(5'd26, 32'h0000_0001, "x26 slt mixed signs");
    issue_legal(enc_r(7'd0, 5'd5, 5'd19, rv_pkg::F3_SLTU, 5'd27), "sltu x27, x19, x5");
    expect_reg(5'd27, 32'h0000_0000, "x27 sltu mixed signs");
    // Shift amount is x6[4:0] = 27
    issue_legal(enc_r(7'd0, 5'd6, 5'd6, rv_pkg::F3_SR, 5'd28), "srl x28, x6, x6");
    expect_reg(5'd28, 32'h0000_001f, "x28 srl low five bits");

    // Special destinations
    issue_legal(enc_i(12'd7, 5'd5, rv_pkg::F3_ADD_SUB, 5'd0), "addi x0, x5, 7");
    expect_reg(5'd0, 32'h0000_0000, "x0 stays zero");
    issue_legal(enc_i(12'd1, 5'd5, rv_pkg::F3_ADD_SUB, 5'd1), "addi ra, x5, 1");
    expect_reg(5'd1, 32'h0000_0065, "ra write");
    issue_legal(enc_i(12'hff0, 5'd2, rv_pkg::F3_ADD_SUB, 5'd2), "addi sp, sp, -16");
    expect_reg(5'd2, 32'h0000_0ff0, "sp write");
    issue_legal(enc_r(7'd0, 5'd2, 5'd1, rv_pkg::F3_ADD_SUB, 5'd31), "add x31, ra, sp");
    expect_reg(5'd31, 32'h0000_1055, "x31 write");

    // Guard load then overwrite
    add_write(rv_pkg::ADDR_RA_GUARD, 32'h1234_5678, 1'b0, "ra guard load");
    expect_reg(5'd1, 32'hffff_ffff, "ra guard value");
    issue_legal(enc_i(12'd2, 5'd1, rv_pkg::F3_ADD_SUB, 5'd1), "addi ra, ra, 2");
    expect_reg(5'd1, 32'h0000_0001, "ra after guard overwrite");

    // Illegal words and bad writes leave the destination alone
    issue_illegal(enc_r(7'h01, 5'd5, 5'd5, rv_pkg::F3_ADD_SUB, 5'd18), "mul word x18");
    expect_reg(5'd18, 32'h0000_005f, "x18 kept");
    issue_illegal(enc_r(rv_pkg::F7_ALT, 5'd5, 5'd6, rv_pkg::F3_AND, 5'd20), "alt and x20");
    expect_reg(5'd20, 32'h0000_0760, "x20 kept");
    issue_illegal(enc_i({rv_pkg::F7_ALT, 5'd1}, 5'd5, rv_pkg::F3_SLL, 5'd13), "alt slli x13");
    expect_reg(5'd13, 32'h0000_0640, "x13 kept");
    issue_illegal(enc_i({7'h10, 5'd1}, 5'd5, rv_pkg::F3_SR, 5'd14), "bad srli x14");
    expect_reg(5'd14, 32'h0000_000f, "x14 kept");
    issue_illegal({20'h12345, 5'd15, 7'b0110111}, "lui x15");
    expect_reg(5'd15, 32'hffff_fffd, "x15 kept");
    add_write(win_addr(5'd5), 32'h0000_dead, 1'b1, "write to window x5");
    expect_reg(5'd5, 32'h0000_0064, "x5 kept after window write");
    add_write(8'h08, enc_i(12'd1, 5'd0, rv_pkg::F3_ADD_SUB, 5'd5), 1'b1, "write unmapped");
    expect_reg(5'd5, 32'h0000_0064, "x5 kept after unmapped write");

    cycle_limit = 4 * row_name.size() + 20;

    wait (rst === 1'b0);
    for (int i = 0; i < row_name.size(); i++) begin
      bus_cycle(row_write[i], row_addr[i], row_data[i], rdata, got_ack, got_err);
      check_resp({row_name[i], " ack"}, !row_err[i], got_ack);
      check_resp({row_name[i], " err"}, row_err[i], got_err);
      if (!row_write[i] && !row_err[i]) begin
        check_word(row_name[i], row_exp[i], rdata);
      end
    end

    $display("Verification passed");
    $finish;
  end

endmodule

`default_nettype wire

/* exec_unit_top.f */
src/rv_pkg.sv
src/reg_bank.sv
src/register_file.sv
src/instr_decoder.sv
src/alu.sv
src/wb_exec_slave.sv
src/exec_unit_top.sv
dv/clk_gen.sv
dv/exec_unit_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       := exec_unit_tb
FILELIST  := exec_unit_top.f
VFLAGS    := --binary --timing --assert -j 0
OBJ_DIR   := obj_dir
LOG       := sim.log
FAIL_MSG  := Verification failed
PASS_MSG  := Verification passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "No result found in $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
